// File: source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    localparam int unsigned INSTR_W = 32;

    // low bit of each instruction field
    localparam int unsigned COND_LSB     = 28;
    localparam int unsigned OPCODE_LSB   = 21;
    localparam int unsigned RD_LSB       = 17;
    localparam int unsigned RN_LSB       = 13;
    localparam int unsigned RS_LSB       = 9;
    localparam int unsigned IMM5_LSB     = 4;
    localparam int unsigned SHIFT_OP_LSB = 5;
    localparam int unsigned RM_LSB       = 0;
    localparam int unsigned IMM12_LSB    = 0;
    localparam int unsigned BR_OFF_LSB   = 0;
    localparam int unsigned BR_OFF_W     = 21;

    // fill counts at which each stage opens
    localparam logic [2:0] FILL_CYCLES = 3'd5;
    localparam logic [2:0] EXEC_START  = 3'd2;
    localparam logic [2:0] WAIT_START  = 3'd4;
    localparam logic [2:0] WB_START    = 3'd5;

    localparam logic [3:0] LINK_REG = 4'd14;

    typedef enum logic [6:0] {
        ADD_R = 7'h00, ADD_I = 7'h01, SUB_R = 7'h02, SUB_I = 7'h03,
        AND_R = 7'h04, ORR_R = 7'h05, MOV_R = 7'h06, MOV_I = 7'h07,
        CMP_R = 7'h08, LDR   = 7'h10, STR   = 7'h11, B     = 7'h20,
        BL    = 7'h21, NOP   = 7'h7f
    } opcode_t;

    typedef enum logic [3:0] {
        EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3, MI = 4'h4, PL = 4'h5, AL = 4'he
    } cond_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_PASS} alu_op_t;
    typedef enum logic [1:0] {PC_SEQ, PC_RESET, PC_BRANCH} pc_sel_t;
    typedef enum logic [1:0] {WADDR_RD, WADDR_LR} waddr_sel_t;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM} fwd_sel_t;
    typedef enum logic [1:0] {LOAD_PC, FILL, RUN} seq_state_t;

    localparam pc_sel_t RESET_VECTOR_SEL = PC_RESET;

    typedef struct packed {
        logic execute;
        logic memory_wait;
        logic write_back;
    } stage_en_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rn;
        logic [3:0] rs;
        logic [3:0] rm;
        logic [4:0] imm5;
        fwd_sel_t   sel_a_in;
        fwd_sel_t   sel_b_in;
        fwd_sel_t   sel_shift_in;
        logic       sel_shift;
        logic       en_a;
        logic       en_b;
        logic       en_s;
    } exec_ctrl_t;

    typedef struct packed {
        cond_t              cond;
        opcode_t            opcode;
        logic [3:0]         rd;
        logic [1:0]         shift_op;
        logic [11:0]        imm12;
        logic [INSTR_W-1:0] imm_branch;
        pc_sel_t            sel_pc;
        logic               load_pc;
        logic               sel_branch_imm;
        logic               sel_a;
        logic               sel_b;
        alu_op_t            alu_op;
        logic               sel_pre_indexed;
        logic               en_status;
        waddr_sel_t         sel_w_addr1;
        logic               w_en1;
        logic               mem_w_en;
    } mem_ctrl_t;

endpackage

`default_nettype wire

// File: source/fill_counter.sv
`timescale 1ns/100ps
`default_nettype none

module fill_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fill_run,
    output logic [2:0] fill_count
);
    import ctrl_pkg::*;

    // saturates so the stage enables stay up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_count <= '0;
        end else if (fill_run && (fill_count != FILL_CYCLES)) begin
            fill_count <= fill_count + 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          fill_count,
    output logic                fill_run,
    output ctrl_pkg::stage_en_t stage_en,
    output logic                reset_pc
);
    import ctrl_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOAD_PC;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOAD_PC: state_next = FILL;
            // last fill cycle once the counter has saturated
            FILL: begin
                if (fill_count == FILL_CYCLES) begin
                    state_next = RUN;
                end
            end
            RUN: state_next = RUN;
            default: state_next = LOAD_PC;
        endcase
    end

    // counting starts with the reset-vector cycle
    assign fill_run = (state != RUN);
    assign reset_pc = (state == LOAD_PC);

    assign stage_en.execute     = (state == RUN) || (fill_count >= EXEC_START);
    assign stage_en.memory_wait = (state == RUN) || (fill_count >= WAIT_START);
    assign stage_en.write_back  = (state == RUN) || (fill_count >= WB_START);

endmodule

`default_nettype wire

// File: source/execute_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module execute_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ctrl_pkg::INSTR_W-1:0] instr_in,
    input  logic                         enable,
    input  logic                         branch_ref,
    input  logic [3:0]                   mem_rd,
    input  logic                         mem_writes,
    output ctrl_pkg::exec_ctrl_t         exec_ctrl,
    output logic [ctrl_pkg::INSTR_W-1:0] instr_out,
    output logic                         valid_out,
    output logic                         tag_out
);
    import ctrl_pkg::*;

    logic [INSTR_W-1:0] instr_q;
    logic               valid_q;
    logic               tag_q;
    opcode_t            opcode;
    logic [3:0]         rn;
    logic [3:0]         rs;
    logic [3:0]         rm;
    logic               reg_form;
    logic               shift_by_rs;

    // tag is checked against the live reference two stages later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            tag_q   <= 1'b0;
        end else begin
            valid_q <= enable;
            if (enable) begin
                tag_q <= branch_ref;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            instr_q <= instr_in;
        end
    end

    assign opcode = opcode_t'(instr_q[OPCODE_LSB +: $bits(opcode_t)]);
    assign rn     = instr_q[RN_LSB +: 4];
    assign rs     = instr_q[RS_LSB +: 4];
    assign rm     = instr_q[RM_LSB +: 4];

    assign reg_form    = opcode inside {ADD_R, SUB_R, AND_R, ORR_R, MOV_R, CMP_R};
    // nonzero rs means a register-specified shift
    assign shift_by_rs = valid_q && reg_form && (rs != 4'd0);

    always_comb begin
        exec_ctrl.opcode    = opcode;
        exec_ctrl.rn        = rn;
        exec_ctrl.rs        = rs;
        exec_ctrl.rm        = rm;
        exec_ctrl.imm5      = instr_q[IMM5_LSB +: 5];
        exec_ctrl.en_a      = valid_q && !(opcode inside {MOV_R, MOV_I, B, BL, NOP});
        exec_ctrl.en_b      = valid_q && reg_form;
        exec_ctrl.en_s      = shift_by_rs;
        exec_ctrl.sel_shift = shift_by_rs;
        // bypass from the instruction one stage ahead
        exec_ctrl.sel_a_in     = (mem_writes && (rn == mem_rd)) ? FWD_MEM : FWD_REG;
        exec_ctrl.sel_b_in     = (mem_writes && (rm == mem_rd)) ? FWD_MEM : FWD_REG;
        exec_ctrl.sel_shift_in = (mem_writes && (rs == mem_rd)) ? FWD_MEM : FWD_REG;
    end

    assign instr_out = instr_q;
    assign valid_out = valid_q;
    assign tag_out   = tag_q;

endmodule

`default_nettype wire

// File: source/memory_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module memory_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ctrl_pkg::INSTR_W-1:0] instr_in,
    input  logic                         valid_in,
    input  logic                         tag_in,
    input  logic [ctrl_pkg::INSTR_W-1:0] status_reg,
    input  logic                         reset_pc,
    output ctrl_pkg::mem_ctrl_t          mem_ctrl,
    output logic [3:0]                   mem_rd,
    output logic                         mem_writes,
    output logic                         branch_ref,
    output logic                         ldr_commit,
    output logic [ctrl_pkg::INSTR_W-1:0] instr_out
);
    import ctrl_pkg::*;

    logic [INSTR_W-1:0] instr_q;
    logic               valid_q;
    logic               tag_q;
    logic               branch_ref_q;
    opcode_t            opcode;
    cond_t              cond;
    logic [3:0]         nzcv;
    logic               cond_pass;
    logic               commit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            tag_q        <= 1'b0;
            branch_ref_q <= 1'b0;
        end else begin
            valid_q <= valid_in;
            tag_q   <= tag_in;
            // taken branch retires everything tagged with the old value
            if (commit && (opcode inside {B, BL})) begin
                branch_ref_q <= ~branch_ref_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_in;
    end

    assign opcode = opcode_t'(instr_q[OPCODE_LSB +: $bits(opcode_t)]);
    assign cond   = cond_t'(instr_q[COND_LSB +: $bits(cond_t)]);
    assign nzcv   = status_reg[31:28];

    // flag order n z c v
    always_comb begin
        case (cond)
            EQ: cond_pass = nzcv[2];
            NE: cond_pass = !nzcv[2];
            CS: cond_pass = nzcv[1];
            CC: cond_pass = !nzcv[1];
            MI: cond_pass = nzcv[3];
            PL: cond_pass = !nzcv[3];
            AL: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    assign commit = valid_q && (tag_q == branch_ref_q) && cond_pass;

    always_comb begin
        mem_ctrl            = '0;
        mem_ctrl.cond       = cond;
        mem_ctrl.opcode     = opcode;
        mem_ctrl.rd         = instr_q[RD_LSB +: 4];
        mem_ctrl.shift_op   = instr_q[SHIFT_OP_LSB +: 2];
        mem_ctrl.imm12      = instr_q[IMM12_LSB +: 12];
        mem_ctrl.imm_branch = {{(INSTR_W - BR_OFF_W){instr_q[BR_OFF_LSB + BR_OFF_W - 1]}},
                               instr_q[BR_OFF_LSB +: BR_OFF_W]};
        mem_ctrl.sel_pc      = PC_SEQ;
        mem_ctrl.load_pc     = 1'b1;
        mem_ctrl.alu_op      = ALU_PASS;
        mem_ctrl.sel_w_addr1 = WADDR_RD;
        case (opcode)
            ADD_R, ADD_I: begin
                mem_ctrl.alu_op = ALU_ADD;
                mem_ctrl.sel_b  = (opcode == ADD_I);
                mem_ctrl.w_en1  = 1'b1;
            end
            SUB_R, SUB_I: begin
                mem_ctrl.alu_op    = ALU_SUB;
                mem_ctrl.sel_b     = (opcode == SUB_I);
                mem_ctrl.en_status = (opcode == SUB_R);
                mem_ctrl.w_en1     = 1'b1;
            end
            AND_R: begin
                mem_ctrl.alu_op = ALU_AND;
                mem_ctrl.w_en1  = 1'b1;
            end
            ORR_R: begin
                mem_ctrl.alu_op = ALU_ORR;
                mem_ctrl.w_en1  = 1'b1;
            end
            MOV_R, MOV_I: begin
                mem_ctrl.sel_b = (opcode == MOV_I);
                mem_ctrl.w_en1 = 1'b1;
            end
            CMP_R: begin
                mem_ctrl.alu_op    = ALU_SUB;
                mem_ctrl.en_status = 1'b1;
            end
            // address is base plus imm12
            LDR, STR: begin
                mem_ctrl.alu_op          = ALU_ADD;
                mem_ctrl.sel_b           = 1'b1;
                mem_ctrl.sel_pre_indexed = 1'b1;
                mem_ctrl.mem_w_en        = (opcode == STR);
            end
            B, BL: begin
                mem_ctrl.sel_pc         = PC_BRANCH;
                mem_ctrl.sel_branch_imm = 1'b1;
                if (opcode == BL) begin
                    // return address into the link register
                    mem_ctrl.sel_a       = 1'b1;
                    mem_ctrl.sel_w_addr1 = WADDR_LR;
                    mem_ctrl.w_en1       = 1'b1;
                end
            end
            default: ;
        endcase
        if (!commit) begin
            mem_ctrl.sel_pc         = PC_SEQ;
            mem_ctrl.sel_branch_imm = 1'b0;
            mem_ctrl.en_status      = 1'b0;
            mem_ctrl.sel_w_addr1    = WADDR_RD;
            mem_ctrl.w_en1          = 1'b0;
            mem_ctrl.mem_w_en       = 1'b0;
        end
        if (reset_pc) begin
            mem_ctrl.sel_pc  = RESET_VECTOR_SEL;
            mem_ctrl.load_pc = 1'b1;
        end
    end

    assign mem_rd     = (opcode == BL) ? LINK_REG : instr_q[RD_LSB +: 4];
    assign mem_writes = mem_ctrl.w_en1;
    assign ldr_commit = commit && (opcode == LDR);
    assign branch_ref = branch_ref_q;
    assign instr_out  = instr_q;

endmodule

`default_nettype wire

// File: source/writeback_tail.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_tail (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ctrl_pkg::stage_en_t          stage_en,
    input  logic                         ldr_commit,
    input  logic [ctrl_pkg::INSTR_W-1:0] instr_in,
    output logic                         w_en_ldr
);
    import ctrl_pkg::*;

    logic [INSTR_W-1:0] wait_instr;
    logic               wait_ldr;
    logic               wb_ldr;

    // a closed stage holds a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_ldr <= 1'b0;
            wb_ldr   <= 1'b0;
        end else begin
            wait_ldr <= stage_en.memory_wait && ldr_commit;
            wb_ldr   <= stage_en.write_back && wait_ldr &&
                        (opcode_t'(wait_instr[OPCODE_LSB +: $bits(opcode_t)]) == LDR);
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en.memory_wait) begin
            wait_instr <= instr_in;
        end
    end

    assign w_en_ldr = wb_ldr;

endmodule

`default_nettype wire

// File: source/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ctrl_pkg::INSTR_W-1:0] instr_in,
    input  logic [ctrl_pkg::INSTR_W-1:0] status_reg,
    output ctrl_pkg::exec_ctrl_t         exec_ctrl,
    output ctrl_pkg::mem_ctrl_t          mem_ctrl,
    output logic                         w_en_ldr
);
    import ctrl_pkg::*;

    logic               fill_run;
    logic [2:0]         fill_count;
    stage_en_t          stage_en;
    logic               reset_pc;

    // execute to memory
    logic [INSTR_W-1:0] ex_instr;
    logic               ex_valid;
    logic               ex_tag;

    // memory back to execute and on to the tail
    logic [3:0]         mem_rd;
    logic               mem_writes;
    logic               branch_ref;
    logic               ldr_commit;
    logic [INSTR_W-1:0] mem_instr;

    pipe_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_count (fill_count),
        .fill_run   (fill_run),
        .stage_en   (stage_en),
        .reset_pc   (reset_pc)
    );

    fill_counter u_fill_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_run   (fill_run),
        .fill_count (fill_count)
    );

    execute_decoder u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_in   (instr_in),
        .enable     (stage_en.execute),
        .branch_ref (branch_ref),
        .mem_rd     (mem_rd),
        .mem_writes (mem_writes),
        .exec_ctrl  (exec_ctrl),
        .instr_out  (ex_instr),
        .valid_out  (ex_valid),
        .tag_out    (ex_tag)
    );

    memory_decoder u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_in   (ex_instr),
        .valid_in   (ex_valid),
        .tag_in     (ex_tag),
        .status_reg (status_reg),
        .reset_pc   (reset_pc),
        .mem_ctrl   (mem_ctrl),
        .mem_rd     (mem_rd),
        .mem_writes (mem_writes),
        .branch_ref (branch_ref),
        .ldr_commit (ldr_commit),
        .instr_out  (mem_instr)
    );

    writeback_tail u_tail (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_en   (stage_en),
        .ldr_commit (ldr_commit),
        .instr_in   (mem_instr),
        .w_en_ldr   (w_en_ldr)
    );

endmodule

`default_nettype wire

// File: bench/controller_sva.sv
`timescale 1ns/100ps
`default_nettype none

module controller_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                reset_pc,
    input ctrl_pkg::stage_en_t stage_en,
    input logic                squashed,
    input logic                w_en1,
    input logic                mem_w_en,
    input logic                en_status
);
    // reset vector load lasts exactly one cycle
    assert property (@(posedge clk) $rose(rst_n) |-> reset_pc)
        else $error("reset_pc not raised after reset");
    assert property (@(posedge clk) disable iff (!rst_n) reset_pc |=> !reset_pc)
        else $error("reset_pc held longer than one cycle");

    // an open stage stays open through fill and RUN
    assert property (@(posedge clk) disable iff (!rst_n)
                     (($past(stage_en) & ~stage_en) == 3'b000))
        else $error("stage enable dropped after the stage had opened");

    assert property (@(posedge clk) disable iff (!rst_n)
                     squashed |-> !(w_en1 || mem_w_en || en_status))
        else $error("write enabled for a squashed instruction");

endmodule

bind pipe_sequencer controller_sva sequencer_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .reset_pc  (reset_pc),
    .stage_en  (stage_en),
    .squashed  (1'b0),
    .w_en1     (1'b0),
    .mem_w_en  (1'b0),
    .en_status (1'b0)
);

bind memory_decoder controller_sva squash_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .reset_pc  (reset_pc),
    .stage_en  (3'b000),
    .squashed  (valid_q && (tag_q != branch_ref_q)),
    .w_en1     (mem_ctrl.w_en1),
    .mem_w_en  (mem_ctrl.mem_w_en),
    .en_status (mem_ctrl.en_status)
);

`default_nettype wire

// File: bench/controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module controller_tb;
    import ctrl_pkg::*;

    logic               clk;
    logic               rst_n;
    logic [INSTR_W-1:0] instr_in;
    logic [INSTR_W-1:0] status_reg;
    exec_ctrl_t         exec_ctrl;
    mem_ctrl_t          mem_ctrl;
    logic               w_en_ldr;

    logic [31:0] instr_list [$];
    logic [31:0] status_list [$];
    exec_ctrl_t  exp_exec [$];
    mem_ctrl_t   exp_mem [$];
    logic        exp_wen [$];
    int          line_errs [$];
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    // AL NOP keeps the pipeline quiet
    localparam logic [31:0] IDLE_INSTR = 32'he_fe0_0000;

    controller dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_in   (instr_in),
        .status_reg (status_reg),
        .exec_ctrl  (exec_ctrl),
        .mem_ctrl   (mem_ctrl),
        .w_en_ldr   (w_en_ldr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && cycle_limit != 0) begin
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: pipeline did not finish within %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    task automatic record_error(input int line);
        errors++;
        if (line >= 0) begin
            line_errs[line]++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       text;
        logic [31:0] ins;
        logic [31:0] st;
        logic [31:0] c [19];
        exec_ctrl_t  e;
        mem_ctrl_t   m;
        fd = $fopen("bench/controller_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
        end
        while (fd != 0 && !$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            ins, st, c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8],
                            c[9], c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], c[18]);
                if (n == 21) begin
                    // fields come straight from the instruction format
                    e.opcode       = opcode_t'(ins[27:21]);
                    e.rn           = ins[16:13];
                    e.rs           = ins[12:9];
                    e.rm           = ins[3:0];
                    e.imm5         = ins[8:4];
                    e.sel_a_in     = fwd_sel_t'(c[0][1:0]);
                    e.sel_b_in     = fwd_sel_t'(c[1][1:0]);
                    e.sel_shift_in = fwd_sel_t'(c[2][1:0]);
                    e.sel_shift    = c[3][0];
                    e.en_a         = c[4][0];
                    e.en_b         = c[5][0];
                    e.en_s         = c[6][0];
                    m.cond            = cond_t'(ins[31:28]);
                    m.opcode          = opcode_t'(ins[27:21]);
                    m.rd              = ins[20:17];
                    m.shift_op        = ins[6:5];
                    m.imm12           = ins[11:0];
                    m.imm_branch      = {{11{ins[20]}}, ins[20:0]};
                    m.sel_pc          = pc_sel_t'(c[7][1:0]);
                    m.load_pc         = c[8][0];
                    m.sel_branch_imm  = c[9][0];
                    m.sel_a           = c[10][0];
                    m.sel_b           = c[11][0];
                    m.alu_op          = alu_op_t'(c[12][2:0]);
                    m.sel_pre_indexed = c[13][0];
                    m.en_status       = c[14][0];
                    m.sel_w_addr1     = waddr_sel_t'(c[15][1:0]);
                    m.w_en1           = c[16][0];
                    m.mem_w_en        = c[17][0];
                    instr_list.push_back(ins);
                    status_list.push_back(st);
                    exp_exec.push_back(e);
                    exp_mem.push_back(m);
                    exp_wen.push_back(c[18][0]);
                    line_errs.push_back(0);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (instr_list.size() == 0) begin
            $display("no test lines were read from the stimulus file");
            errors++;
        end
    endtask

    task automatic check_exec(input int line);
        checks++;
        assert (exec_ctrl === exp_exec[line]) else begin
            $display("** Error at %0t: exec_ctrl expected %h got %h (line %0d)",
                     $time, exp_exec[line], exec_ctrl, line);
            record_error(line);
        end
    endtask

    task automatic check_mem(input int line);
        checks++;
        assert (mem_ctrl === exp_mem[line]) else begin
            $display("** Error at %0t: mem_ctrl expected %h got %h (line %0d)",
                     $time, exp_mem[line], mem_ctrl, line);
            record_error(line);
        end
    endtask

    task automatic check_wen(input int line, input logic exp);
        checks++;
        assert (w_en_ldr === exp) else begin
            $display("** Error at %0t: w_en_ldr expected %b got %b (line %0d)",
                     $time, exp, w_en_ldr, line);
            record_error(line);
        end
    endtask

    // memory stage still holds a bubble
    task automatic check_quiet();
        checks++;
        assert (mem_ctrl.w_en1 === 1'b0 && mem_ctrl.mem_w_en === 1'b0 &&
                mem_ctrl.en_status === 1'b0 && mem_ctrl.sel_pc === PC_SEQ) else begin
            $display("** Error at %0t: mem_ctrl w_en1/mem_w_en/en_status/sel_pc %s %0d got %b/%b/%b/%0d",
                     $time, "expected 0/0/0/", PC_SEQ, mem_ctrl.w_en1, mem_ctrl.mem_w_en,
                     mem_ctrl.en_status, mem_ctrl.sel_pc);
            record_error(-1);
        end
    endtask

    initial begin
        int n_lines;
        int reset_errs;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_in    = IDLE_INSTR;
        status_reg  = '0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        load_stimulus();
        n_lines     = instr_list.size();
        cycle_limit = n_lines + FILL_CYCLES + 20;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #2;
        checks++;
        assert (mem_ctrl.sel_pc === PC_RESET && mem_ctrl.load_pc === 1'b1) else begin
            $display("** Error at %0t: mem_ctrl.sel_pc/load_pc expected %0d/1 got %0d/%b",
                     $time, PC_RESET, mem_ctrl.sel_pc, mem_ctrl.load_pc);
            record_error(-1);
        end
        @(negedge clk);
        #2;
        check_quiet();
        check_wen(-1, 1'b0);
        reset_errs = errors;
        $display("reset and fill: %s", (reset_errs == 0) ? "ok" : "failed");

        // line k sampled by execute at the next rising edge
        for (int k = 0; k < n_lines + 4; k++) begin
            @(negedge clk);
            instr_in   = (k < n_lines) ? instr_list[k] : IDLE_INSTR;
            status_reg = (k >= 2 && k - 2 < n_lines) ? status_list[k - 2] : '0;
            #2;
            if (k >= 1 && k - 1 < n_lines) begin
                check_exec(k - 1);
            end
            if (k >= 2 && k - 2 < n_lines) begin
                check_mem(k - 2);
            end else if (k < 2) begin
                check_quiet();
            end
            if (k >= 4) begin
                check_wen(k - 4, exp_wen[k - 4]);
                $display("line %0d: %s", k - 4, (line_errs[k - 4] == 0) ? "ok" : "failed");
            end else begin
                check_wen(-1, 1'b0);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/controller_stimulus.txt
# instr status | exec: sel_a_in sel_b_in sel_shift_in sel_shift en_a en_b en_s
# mem: sel_pc load_pc sel_branch_imm sel_a sel_b alu_op pre_idx en_status waddr w_en1 mem_w_en | w_en_ldr
e0024003 00000000 0 0 0 0 1 1 0 0 1 0 0 0 0 0 0 0 1 0 0
e0482001 00000000 1 1 0 0 1 1 0 0 1 0 0 0 1 0 1 0 1 0 0
e0aa4806 00000000 0 0 1 1 1 1 1 0 1 0 0 0 3 0 0 0 1 0 0
002ca010 00000000 1 0 0 0 1 0 0 0 1 0 0 1 0 0 0 0 0 0 0
102ec010 00000000 0 0 0 0 1 0 0 0 1 0 0 1 0 0 0 0 1 0 0
e100e007 00000000 1 1 0 0 1 1 0 0 1 0 0 0 1 0 1 0 0 0 0
e0f00020 00000000 0 0 0 0 0 0 0 0 1 0 0 1 4 0 0 0 1 0 0
e2130004 00000000 1 0 0 0 1 0 0 0 1 0 0 1 0 1 0 0 0 0 1
e2330008 00000000 0 0 0 0 1 0 0 0 1 0 0 1 0 1 0 0 0 1 0
e4000040 00000000 0 0 0 0 0 0 0 2 1 1 0 0 4 0 0 0 0 0 0
e0022001 00000000 0 0 0 0 1 1 0 0 1 0 0 0 0 0 0 0 0 0 0
e0c40001 00000000 0 0 0 0 0 1 0 0 1 0 0 0 4 0 0 0 0 0 0
243ffff0 20000000 0 0 0 0 0 0 0 2 1 1 1 0 4 0 0 1 1 0 0
e007c002 00000000 1 0 0 0 1 1 0 0 1 0 0 0 0 0 0 0 0 0 0
e0686001 00000000 0 0 0 0 1 0 0 0 1 0 0 1 1 0 0 0 0 0 0
308a6004 00000000 0 0 0 0 1 1 0 0 1 0 0 0 2 0 0 0 1 0 0
420ca000 00000000 1 0 0 0 1 0 0 0 1 0 0 1 0 1 0 0 0 0 0
5fe00000 00000000 0 0 0 0 0 0 0 0 1 0 0 0 4 0 0 0 0 0 0

// File: verilog.f
source/ctrl_pkg.sv
source/fill_counter.sv
source/pipe_sequencer.sv
source/execute_decoder.sv
source/memory_decoder.sv
source/writeback_tail.sv
source/controller.sv
bench/controller_sva.sv
bench/controller_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= controller_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
